// File: include/kmeans_config.svh
`ifndef KMEANS_CONFIG_SVH
`define KMEANS_CONFIG_SVH

// Depth of the point store.
`define KM_MAX_POINTS 16

// Width of one unsigned coordinate.
`define KM_COORD_WIDTH 16

`endif

// File: source/kmeans_data_pkg.sv
`default_nettype none
`include "kmeans_config.svh"

package kmeans_data_pkg;

    typedef logic [`KM_COORD_WIDTH-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // One extra bit holds the sum of the two coordinate differences.
    typedef logic [`KM_COORD_WIDTH:0] dist_t;
    typedef logic [`KM_COORD_WIDTH+$clog2(`KM_MAX_POINTS+1)-1:0] sum_t;
    typedef logic [$clog2(`KM_MAX_POINTS+1)-1:0] count_t;
    typedef logic [$clog2(`KM_MAX_POINTS)-1:0] index_t;

    typedef struct packed {
        point_t centroid_0;
        point_t centroid_1;
        count_t count_0;
        count_t count_1;
    } centroid_result_t;

endpackage

`default_nettype wire

// File: source/kmeans_ctrl_pkg.sv
`default_nettype none

package kmeans_ctrl_pkg;
    import kmeans_data_pkg::*;

    typedef enum logic [2:0] {IDLE, LOAD, ASSIGN, DRAIN, DIVIDE, FINISH} seq_state_t;

    // num_points runs from 1 to the store depth, iterations is at least 1.
    typedef struct packed {
        point_t     init_0;
        point_t     init_1;
        count_t     num_points;
        logic [7:0] iterations;
    } kmeans_job_t;

endpackage

`default_nettype wire

// File: source/point_store.sv
`default_nettype none
`timescale 1ns/1ps
`include "kmeans_config.svh"

module point_store (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    load_en,
    input  wire kmeans_data_pkg::index_t load_index,
    input  wire kmeans_data_pkg::point_t load_point,
    input  wire kmeans_data_pkg::index_t read_index,
    output kmeans_data_pkg::point_t      read_point
);
    import kmeans_data_pkg::*;

    point_t mem [`KM_MAX_POINTS];

    // The engine sees the addressed point one cycle after it presents the index.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_index] <= load_point;
        end
        read_point <= mem[read_index];
    end

    // An unknown index addresses no defined entry of the array.
    a_load_in_range: assert property (@(posedge clk) disable iff (reset)
        load_en |-> !$isunknown(load_index));

endmodule

`default_nettype wire

// File: source/pass_counter.sv
`default_nettype none
`timescale 1ns/1ps

module pass_counter (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    pass_clear,
    input  wire logic                    step,
    input  wire logic                    iter_done_en,
    input  wire kmeans_data_pkg::count_t num_points,
    input  wire logic [7:0]              iterations,
    output kmeans_data_pkg::index_t      index,
    output logic                         last_point,
    output logic                         last_iter
);
    import kmeans_data_pkg::*;

    index_t     index_next;
    logic [7:0] iter_count;
    logic [7:0] iter_next;

    always_comb begin
        index_next = index;
        if (pass_clear) begin
            index_next = '0;
        end else if (step) begin
            index_next = index + index_t'(1);
        end
    end

    // The count wraps to zero after the last iteration, ready for the next job.
    always_comb begin
        iter_next = iter_count;
        if (iter_done_en) begin
            iter_next = last_iter ? 8'd0 : iter_count + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            index      <= '0;
            iter_count <= '0;
            last_point <= 1'b0;
            last_iter  <= 1'b0;
        end else begin
            index      <= index_next;
            iter_count <= iter_next;
            last_point <= (count_t'(index_next) == num_points - count_t'(1));
            last_iter  <= (iter_next == iterations - 8'd1);
        end
    end

    a_step_in_range: assert property (@(posedge clk) disable iff (reset)
        step |-> (count_t'(index) + count_t'(1) < num_points));

endmodule

`default_nettype wire

// File: source/kmeans_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module kmeans_sequencer (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         start,
    input  wire kmeans_ctrl_pkg::kmeans_job_t job,
    input  wire logic                         last_point,
    input  wire logic                         last_iter,
    input  wire logic                         div_done,
    output logic                              busy,
    output logic                              done,
    output logic                              pass_clear,
    output logic                              step,
    output logic                              iter_done_en,
    output logic                              acc_clear,
    output logic                              acc_sample,
    output logic                              centroid_load,
    output logic                              div_start,
    output kmeans_ctrl_pkg::kmeans_job_t      active_job
);
    import kmeans_ctrl_pkg::*;

    seq_state_t state;
    seq_state_t state_next;

    always_comb begin
        state_next    = state;
        pass_clear    = 1'b0;
        step          = 1'b0;
        iter_done_en  = 1'b0;
        acc_clear     = 1'b0;
        centroid_load = 1'b0;
        done          = 1'b0;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = LOAD;
                end
            end
            LOAD: begin
                centroid_load = 1'b1;
                pass_clear    = 1'b1;
                acc_clear     = 1'b1;
                state_next    = ASSIGN;
            end
            ASSIGN: begin
                step = !last_point;
                if (last_point) begin
                    state_next = DRAIN;
                end
            end
            DRAIN: state_next = DIVIDE;
            DIVIDE: begin
                if (div_done) begin
                    iter_done_en = 1'b1;
                    if (last_iter) begin
                        state_next = FINISH;
                    end else begin
                        // Next pass starts with the updated centroids.
                        pass_clear = 1'b1;
                        acc_clear  = 1'b1;
                        state_next = ASSIGN;
                    end
                end
            end
            FINISH: begin
                done       = 1'b1;
                state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    assign busy = (state != IDLE);

    // The sample strobe trails the read index by one cycle, like the store data.
    // The divider starts once the final sample has reached the sums.
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            acc_sample <= 1'b0;
            div_start  <= 1'b0;
        end else begin
            state      <= state_next;
            acc_sample <= (state == ASSIGN);
            div_start  <= (state == DRAIN);
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            active_job <= job;
        end
    end

endmodule

`default_nettype wire

// File: source/cluster_accumulator.sv
`default_nettype none
`timescale 1ns/1ps
`include "kmeans_config.svh"

module cluster_accumulator (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         acc_clear,
    input  wire logic                         acc_sample,
    input  wire logic                         centroid_load,
    input  wire kmeans_ctrl_pkg::kmeans_job_t job,
    input  wire kmeans_data_pkg::point_t      point,
    input  wire logic                         upd_en,
    input  wire logic [1:0]                   upd_slot,
    input  wire kmeans_data_pkg::coord_t      upd_value,
    output kmeans_data_pkg::sum_t [3:0]       sums,
    output kmeans_data_pkg::count_t [1:0]     counts,
    output kmeans_data_pkg::centroid_result_t result
);
    import kmeans_data_pkg::*;

    point_t                  centroid_0;
    point_t                  centroid_1;
    dist_t                   dist_0;
    dist_t                   dist_1;
    logic                    pick_1;
    logic [$bits(count_t):0] count_total;

    function automatic dist_t manhattan(input point_t a, input point_t b);
        coord_t dx;
        coord_t dy;
        dx = (a.x > b.x) ? a.x - b.x : b.x - a.x;
        dy = (a.y > b.y) ? a.y - b.y : b.y - a.y;
        return dist_t'(dx) + dist_t'(dy);
    endfunction

    assign dist_0 = manhattan(point, centroid_0);
    assign dist_1 = manhattan(point, centroid_1);
    // A tie stays in cluster 0.
    assign pick_1 = (dist_1 < dist_0);

    // Sums are ordered x0, y0, x1, y1, the same slot order the divider uses.
    always_ff @(posedge clk) begin
        if (reset || acc_clear) begin
            sums   <= '0;
            counts <= '0;
        end else if (acc_sample) begin
            if (pick_1) begin
                sums[2]   <= sums[2] + sum_t'(point.x);
                sums[3]   <= sums[3] + sum_t'(point.y);
                counts[1] <= counts[1] + count_t'(1);
            end else begin
                sums[0]   <= sums[0] + sum_t'(point.x);
                sums[1]   <= sums[1] + sum_t'(point.y);
                counts[0] <= counts[0] + count_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (centroid_load) begin
            centroid_0 <= job.init_0;
            centroid_1 <= job.init_1;
        end else if (upd_en) begin
            case (upd_slot)
                2'd0: centroid_0.x <= upd_value;
                2'd1: centroid_0.y <= upd_value;
                2'd2: centroid_1.x <= upd_value;
                2'd3: centroid_1.y <= upd_value;
            endcase
        end
    end

    assign result = {centroid_0, centroid_1, counts[0], counts[1]};

    assign count_total = {1'b0, counts[0]} + {1'b0, counts[1]};

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count_total <= `KM_MAX_POINTS);

endmodule

`default_nettype wire

// File: source/centroid_divider.sv
`default_nettype none
`timescale 1ns/1ps

module centroid_divider (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       div_start,
    input  wire kmeans_data_pkg::sum_t [3:0]   sums,
    input  wire kmeans_data_pkg::count_t [1:0] counts,
    output logic                            div_done,
    output logic                            upd_en,
    output logic [1:0]                      upd_slot,
    output kmeans_data_pkg::coord_t         upd_value
);
    import kmeans_data_pkg::*;

    localparam int SUM_W  = $bits(sum_t);
    localparam int CNT_W  = $bits(count_t);
    localparam int BITS_W = $clog2(SUM_W + 1);

    typedef enum logic [1:0] {DIV_IDLE, DIV_LOAD, DIV_SHIFT} div_state_t;

    div_state_t        state;
    logic [1:0]        slot;
    logic [BITS_W-1:0] bits_left;
    sum_t              quotient;
    count_t            remainder;
    count_t            divisor;
    count_t            slot_count;
    sum_t              src_quo;
    count_t            src_rem;
    count_t            src_div;
    logic [CNT_W:0]    partial;
    logic              fits;
    sum_t              quotient_next;
    count_t            remainder_next;

    assign slot_count = counts[slot[1]];

    // The load cycle already performs the first restoring step on the fresh operands.
    assign src_quo = (state == DIV_LOAD) ? sums[slot] : quotient;
    assign src_rem = (state == DIV_LOAD) ? '0 : remainder;
    assign src_div = (state == DIV_LOAD) ? slot_count : divisor;

    assign partial        = {src_rem, src_quo[SUM_W-1]};
    assign fits           = (partial >= {1'b0, src_div});
    assign remainder_next = fits ? count_t'(partial - {1'b0, src_div}) : count_t'(partial);
    assign quotient_next  = {src_quo[SUM_W-2:0], fits};

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= DIV_IDLE;
            div_done <= 1'b0;
            upd_en   <= 1'b0;
        end else begin
            div_done <= 1'b0;
            upd_en   <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    if (div_start) begin
                        slot  <= 2'd0;
                        state <= DIV_LOAD;
                    end
                end
                DIV_LOAD: begin
                    if (slot_count == '0) begin
                        // An empty cluster keeps its old centroid.
                        slot <= slot + 2'd1;
                        if (slot == 2'd3) begin
                            div_done <= 1'b1;
                            state    <= DIV_IDLE;
                        end
                    end else begin
                        quotient  <= quotient_next;
                        remainder <= remainder_next;
                        divisor   <= slot_count;
                        bits_left <= BITS_W'(SUM_W - 1);
                        state     <= DIV_SHIFT;
                    end
                end
                DIV_SHIFT: begin
                    quotient  <= quotient_next;
                    remainder <= remainder_next;
                    bits_left <= bits_left - BITS_W'(1);
                    if (bits_left == BITS_W'(1)) begin
                        upd_en    <= 1'b1;
                        upd_slot  <= slot;
                        upd_value <= coord_t'(quotient_next);
                        slot      <= slot + 2'd1;
                        if (slot == 2'd3) begin
                            div_done <= 1'b1;
                            state    <= DIV_IDLE;
                        end else begin
                            state <= DIV_LOAD;
                        end
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/two_kmeans_top.sv
`default_nettype none
`timescale 1ns/1ps

module two_kmeans_top (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         load_en,
    input  wire kmeans_data_pkg::index_t      load_index,
    input  wire kmeans_data_pkg::point_t      load_point,
    input  wire logic                         start,
    input  wire kmeans_ctrl_pkg::kmeans_job_t job,
    output logic                              busy,
    output logic                              done,
    output kmeans_data_pkg::centroid_result_t result
);
    import kmeans_data_pkg::*;
    import kmeans_ctrl_pkg::*;

    index_t       read_index;
    point_t       read_point;
    kmeans_job_t  active_job;
    logic         pass_clear;
    logic         step;
    logic         iter_done_en;
    logic         last_point;
    logic         last_iter;
    logic         acc_clear;
    logic         acc_sample;
    logic         centroid_load;
    logic         div_start;
    logic         div_done;
    sum_t [3:0]   sums;
    count_t [1:0] counts;
    logic         upd_en;
    logic [1:0]   upd_slot;
    coord_t       upd_value;

    point_store point_store_inst (
        .clk(clk),
        .reset(reset),
        .load_en(load_en),
        .load_index(load_index),
        .load_point(load_point),
        .read_index(read_index),
        .read_point(read_point)
    );

    pass_counter pass_counter_inst (
        .clk(clk),
        .reset(reset),
        .pass_clear(pass_clear),
        .step(step),
        .iter_done_en(iter_done_en),
        .num_points(active_job.num_points),
        .iterations(active_job.iterations),
        .index(read_index),
        .last_point(last_point),
        .last_iter(last_iter)
    );

    kmeans_sequencer kmeans_sequencer_inst (
        .clk(clk),
        .reset(reset),
        .start(start),
        .job(job),
        .last_point(last_point),
        .last_iter(last_iter),
        .div_done(div_done),
        .busy(busy),
        .done(done),
        .pass_clear(pass_clear),
        .step(step),
        .iter_done_en(iter_done_en),
        .acc_clear(acc_clear),
        .acc_sample(acc_sample),
        .centroid_load(centroid_load),
        .div_start(div_start),
        .active_job(active_job)
    );

    cluster_accumulator cluster_accumulator_inst (
        .clk(clk),
        .reset(reset),
        .acc_clear(acc_clear),
        .acc_sample(acc_sample),
        .centroid_load(centroid_load),
        .job(active_job),
        .point(read_point),
        .upd_en(upd_en),
        .upd_slot(upd_slot),
        .upd_value(upd_value),
        .sums(sums),
        .counts(counts),
        .result(result)
    );

    centroid_divider centroid_divider_inst (
        .clk(clk),
        .reset(reset),
        .div_start(div_start),
        .sums(sums),
        .counts(counts),
        .div_done(div_done),
        .upd_en(upd_en),
        .upd_slot(upd_slot),
        .upd_value(upd_value)
    );

endmodule

`default_nettype wire

// File: verification/tb_two_kmeans.sv
`default_nettype none
`timescale 1ns/1ps
`include "kmeans_config.svh"

module tb_two_kmeans;
    import kmeans_data_pkg::*;
    import kmeans_ctrl_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int JOB_COUNT  = 7;
    localparam int MAX_ITERS  = 4;
    localparam int WATCHDOG_CYCLES =
        JOB_COUNT * (MAX_ITERS * (`KM_MAX_POINTS + 4 * (`KM_COORD_WIDTH + 6)) + 10);

    logic             clk;
    logic             reset;
    logic             load_en;
    index_t           load_index;
    point_t           load_point;
    logic             start;
    kmeans_job_t      job;
    logic             busy;
    logic             done;
    centroid_result_t result;

    point_t           stored [`KM_MAX_POINTS];
    centroid_result_t expected;
    string            test_name;
    int               seed = 32'h0414_729d;
    int               error_count = 0;
    int               check_count = 0;
    int               done_count = 0;
    logic             done_last = 1'b0;
    kmeans_job_t      job_a;
    kmeans_job_t      job_b;
    int               target;
    int               n;

    two_kmeans_top DUT (
        .clk(clk),
        .reset(reset),
        .load_en(load_en),
        .load_index(load_index),
        .load_point(load_point),
        .start(start),
        .job(job),
        .busy(busy),
        .done(done),
        .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the engine did not finish its jobs in %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    function automatic int abs_diff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    // Plain integer k-means over the stored points, for two clusters.
    function automatic centroid_result_t kmeans_model(input kmeans_job_t j);
        int               cx [2];
        int               cy [2];
        int               sx [2];
        int               sy [2];
        int               cnt [2];
        int               d0;
        int               d1;
        int               c;
        int               it;
        int               i;
        centroid_result_t r;
        cx[0] = int'(j.init_0.x);
        cy[0] = int'(j.init_0.y);
        cx[1] = int'(j.init_1.x);
        cy[1] = int'(j.init_1.y);
        for (it = 0; it < int'(j.iterations); it++) begin
            for (c = 0; c < 2; c++) begin
                sx[c]  = 0;
                sy[c]  = 0;
                cnt[c] = 0;
            end
            for (i = 0; i < int'(j.num_points); i++) begin
                d0 = abs_diff(int'(stored[i].x), cx[0]) + abs_diff(int'(stored[i].y), cy[0]);
                d1 = abs_diff(int'(stored[i].x), cx[1]) + abs_diff(int'(stored[i].y), cy[1]);
                // A tie goes to cluster 0.
                c = (d1 < d0) ? 1 : 0;
                sx[c]  = sx[c] + int'(stored[i].x);
                sy[c]  = sy[c] + int'(stored[i].y);
                cnt[c] = cnt[c] + 1;
            end
            for (c = 0; c < 2; c++) begin
                if (cnt[c] != 0) begin
                    cx[c] = sx[c] / cnt[c];
                    cy[c] = sy[c] / cnt[c];
                end
            end
        end
        r.centroid_0.x = coord_t'(cx[0]);
        r.centroid_0.y = coord_t'(cy[0]);
        r.centroid_1.x = coord_t'(cx[1]);
        r.centroid_1.y = coord_t'(cy[1]);
        r.count_0      = count_t'(cnt[0]);
        r.count_1      = count_t'(cnt[1]);
        return r;
    endfunction

    function automatic point_t make_point(input int x, input int y);
        point_t p;
        p.x = coord_t'(x);
        p.y = coord_t'(y);
        return p;
    endfunction

    function automatic kmeans_job_t make_job(input point_t c0, input point_t c1,
                                             input int count, input int iters);
        kmeans_job_t j;
        j.init_0     = c0;
        j.init_1     = c1;
        j.num_points = count_t'(count);
        j.iterations = 8'(iters);
        return j;
    endfunction

    task automatic check_result(input centroid_result_t got, input centroid_result_t exp,
                                input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0d ns: %s: got (%0d,%0d) n=%0d and (%0d,%0d) n=%0d", $time,
                     what, got.centroid_0.x, got.centroid_0.y, got.count_0,
                     got.centroid_1.x, got.centroid_1.y, got.count_1);
            $display("    expected (%0d,%0d) n=%0d and (%0d,%0d) n=%0d",
                     exp.centroid_0.x, exp.centroid_0.y, exp.count_0,
                     exp.centroid_1.x, exp.centroid_1.y, exp.count_1);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0d ns: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic randomize_points(input int count, input int span);
        for (int i = 0; i < count; i++) begin
            stored[i].x = coord_t'($unsigned($random(seed)) % span);
            stored[i].y = coord_t'($unsigned($random(seed)) % span);
        end
    endtask

    task automatic write_points(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            load_en    <= 1'b1;
            load_index <= index_t'(i);
            load_point <= stored[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic wait_done(input int goal);
        while (done_count < goal) begin
            @(posedge clk);
        end
    endtask

    task automatic run_job(input kmeans_job_t j, input string name);
        int goal;
        expected  = kmeans_model(j);
        test_name = name;
        goal      = done_count + 1;
        @(posedge clk);
        start <= 1'b1;
        job   <= j;
        @(posedge clk);
        start <= 1'b0;
        wait_done(goal);
    endtask

    // Every done pulse is compared with the model result of the running job.
    always @(negedge clk) begin
        if (done) begin
            done_count = done_count + 1;
            check_flag(done_last, 1'b0, "done held longer than one cycle");
            check_result(result, expected, test_name);
        end
        done_last = done;
    end

    initial begin
        reset      = 1'b1;
        load_en    = 1'b0;
        load_index = '0;
        load_point = '0;
        start      = 1'b0;
        job        = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");

        randomize_points(16, 65536);
        write_points(16);
        run_job(make_job(stored[0], stored[1], 16, 1), "one iteration");

        for (int k = 0; k < 3; k++) begin
            n = 1 + int'($unsigned($random(seed)) % 16);
            randomize_points(n, 4096);
            write_points(n);
            run_job(make_job(stored[0], stored[n - 1], n, 4), "several iterations");
        end

        // All points sit near the first centroid, so cluster 1 stays empty.
        randomize_points(12, 256);
        write_points(12);
        run_job(make_job(make_point(100, 100), make_point(60000, 60000), 12, 2), "empty cluster");
        @(negedge clk);
        check_flag(result.count_1 == '0, 1'b1, "empty cluster count");
        check_flag(result.centroid_1 == make_point(60000, 60000), 1'b1, "empty cluster centroid");

        // x midway between the centroids and equal y offsets give equal distances.
        for (int i = 0; i < 10; i++) begin
            stored[i] = make_point(2000, int'($unsigned($random(seed)) % 4000));
        end
        write_points(10);
        run_job(make_job(make_point(1000, 2000), make_point(3000, 2000), 10, 1), "ties");
        @(negedge clk);
        check_flag(result.count_0 == count_t'(10), 1'b1, "ties counted in cluster 0");

        randomize_points(16, 1024);
        write_points(16);
        job_a = make_job(stored[2], stored[9], 16, 3);
        job_b = make_job(make_point(5, 5), make_point(900, 900), 4, 1);
        expected  = kmeans_model(job_a);
        test_name = "start while busy";
        target    = done_count + 1;
        @(posedge clk);
        start <= 1'b1;
        job   <= job_a;
        @(posedge clk);
        start <= 1'b0;
        repeat (6) @(posedge clk);
        @(negedge clk);
        check_flag(busy, 1'b1, "busy while the job runs");
        @(posedge clk);
        start <= 1'b1;
        job   <= job_b;
        @(posedge clk);
        start <= 1'b0;
        wait_done(target);
        repeat (40) @(posedge clk);
        @(negedge clk);
        check_flag(done_count == target, 1'b1, "one done pulse for the job");
        check_flag(busy, 1'b0, "engine idle after the job");

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
source/kmeans_data_pkg.sv
source/kmeans_ctrl_pkg.sv
source/point_store.sv
source/pass_counter.sv
source/kmeans_sequencer.sv
source/cluster_accumulator.sv
source/centroid_divider.sv
source/two_kmeans_top.sv
verification/tb_two_kmeans.sv

// File: run.sh
#!/bin/sh
# Builds the two-cluster k-means testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_two_kmeans -o tb_two_kmeans
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_two_kmeans > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
    echo "Simulation ended without a summary"
    exit 1
fi
exit 0
